/* flist.f */
source/isa_pkg.sv
source/core_pkg.sv
source/instr_decode.sv
source/rename_map.sv
source/rob.sv
source/exec_unit.sv
source/ooo_core.sv
tb/tb_ooo_core.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - source/isa_pkg.sv
  - source/core_pkg.sv
  - source/instr_decode.sv
  - source/rename_map.sv
  - source/rob.sv
  - source/exec_unit.sv
  - source/ooo_core.sv
  - target: test
    files:
      - tb/tb_ooo_core.sv

/* tb/tb_ooo_core.sv */
// Testbench for the out-of-order core slice
// Sends words under credit flow control, checks retirements against an in-order model
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core import isa_pkg::*, core_pkg::*; ();

    localparam int ROB_DEPTH  = 8;
    localparam int NUM_RANDOM = 200;

    logic        clock;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        credit_return;
    logic        retire_valid;
    reg_idx_t    retire_dest;
    data_t       retire_value;

    ////////////////////////////////////////////////////////////
    // Golden model state
    data_t    gold_regs [NUM_REGS];
    reg_idx_t exp_dest_q [$];          // Expected retirements, program order
    data_t    exp_value_q [$];
    reg_idx_t head_dest;
    data_t    head_value;
    int       exp_count = 0;

    int credits   = ROB_DEPTH;         // Upstream credit counter
    int sent      = 0;
    int returned  = 0;
    int errors    = 0;
    int cycles    = 0;
    bit credits_ran_out = 1'b0;        // Burst reached zero credits

    ooo_core #(.ROB_DEPTH(ROB_DEPTH)) i_ooo_core (
        .clock, .reset, .instr_valid, .instr,
        .credit_return, .retire_valid, .retire_dest, .retire_value
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;     // 8 ns period
    end

    ////////////////////////////////////////////////////////////
    // Instruction encoders
    function automatic logic [31:0] r_word(input logic [3:0] fn, input int rd, rs1, rs2);
        return {OPC_ALU, 5'(rd), 5'(rs1), 5'(rs2), 7'd0, fn};
    endfunction

    function automatic logic [31:0] i_word(input int rd, rs1, input logic [15:0] imm);
        return {OPC_ADDI, 5'(rd), 5'(rs1), imm};
    endfunction

    function automatic logic [31:0] mul_word(input int rd, rs1, rs2);
        return {OPC_MUL, 5'(rd), 5'(rs1), 5'(rs2), 11'd0};
    endfunction

    task automatic refresh_head();
        exp_count = exp_dest_q.size();
        if (exp_count > 0) begin
            head_dest  = exp_dest_q[0];
            head_value = exp_value_q[0];
        end
    endtask

    // In-order reference execution of one word
    task automatic model_step(input logic [31:0] word);
        logic [5:0] opc;
        reg_idx_t   rd;
        data_t      a;
        data_t      b;
        data_t      val;
        opc = word[31:26];
        rd  = word[25:21];
        a   = gold_regs[word[20:16]];
        b   = gold_regs[word[15:11]];
        val = '0;
        if (opc == OPC_ALU && word[3:0] <= 4'h3) begin
            case (word[3:0])
                FN_ADD:  val = a + b;
                FN_SUB:  val = a - b;
                FN_AND:  val = a & b;
                default: val = a ^ b;
            endcase
        end else if (opc == OPC_ADDI) begin
            val = a + {{16{word[15]}}, word[15:0]};
        end else if (opc == OPC_MUL) begin
            val = a * b;                 // Low word
        end else begin
            rd = '0;                     // No-op retires zero to register 0
        end
        if (rd != '0) gold_regs[rd] = val;
        exp_dest_q.push_back(rd);
        exp_value_q.push_back(val);
        refresh_head();
    endtask

    // Called on a falling edge, returns on the next one
    task automatic send(input logic [31:0] word);
        while (credits == 0) begin
            @(negedge clock);
        end
        instr_valid = 1'b1;
        instr       = word;
        credits--;
        sent++;
        if (credits == 0) credits_ran_out = 1'b1;
        model_step(word);
        @(negedge clock);
        instr_valid = 1'b0;
    endtask

    task automatic print_counts();
        $display("sent %0d, retired %0d, errors %0d", sent, returned, errors);
    endtask

    ////////////////////////////////////////////////////////////
    // Retirement and credit tracking
    always @(posedge clock) begin
        if (!reset && retire_valid && exp_count > 0) begin
            void'(exp_dest_q.pop_front());
            void'(exp_value_q.pop_front());
            refresh_head();
        end
        if (!reset && credit_return) begin
            returned++;
            credits++;
        end
    end

    a_quiet_before_input: assert property (@(posedge clock) disable iff (reset)
        sent == 0 |-> !retire_valid && !credit_return)
        else begin
            errors++;
            $display("a retirement or credit appeared before any instruction was sent");
        end

    a_credit_per_retire: assert property (@(posedge clock) disable iff (reset)
        credit_return == retire_valid)
        else begin
            errors++;
            $display("ERROR %0t: credit_return does not follow retire_valid", $time);
        end

    a_retire_expected: assert property (@(posedge clock) disable iff (reset)
        retire_valid |-> exp_count > 0)
        else begin
            errors++;
            $display("an instruction retired while none was outstanding");
        end

    a_retire_dest: assert property (@(posedge clock) disable iff (reset)
        retire_valid && exp_count > 0 |-> retire_dest == head_dest)
        else begin
            errors++;
            $display("ERROR %0t: retire_dest %0d, expected %0d", $time,
                     $sampled(retire_dest), $sampled(head_dest));
        end

    a_retire_value: assert property (@(posedge clock) disable iff (reset)
        retire_valid && exp_count > 0 |-> retire_value == head_value)
        else begin
            errors++;
            $display("ERROR %0t: retire_value %h, expected %h", $time,
                     $sampled(retire_value), $sampled(head_value));
        end

    // Words sent and not yet retired never exceed the buffer
    a_outstanding: assert property (@(posedge clock) disable iff (reset)
        exp_count <= ROB_DEPTH)
        else begin
            errors++;
            $display("ERROR %0t: %0d instructions outstanding", $time,
                     $sampled(exp_count));
        end

    ////////////////////////////////////////////////////////////
    // Stimulus
    initial begin : stimulus
        int kind;
        int rd;
        int rs1;
        int rs2;
        void'($urandom(32'hdd00_3866));
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < NUM_REGS; i++) gold_regs[i] = '0;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        repeat (6) @(negedge clock);   // Idle, nothing may retire

        // Dependent ALU chain
        send(i_word(1, 0, 16'd5));
        send(i_word(2, 1, 16'hfffd));  // -3
        send(r_word(FN_ADD, 3, 1, 2));
        send(r_word(FN_SUB, 4, 3, 1));
        send(r_word(FN_AND, 5, 4, 3));
        send(r_word(FN_XOR, 6, 5, 1));

        // Multiply overtaken by independent ALU ops, then a bus wakeup
        send(mul_word(8, 1, 2));
        send(r_word(FN_ADD, 9, 3, 4));
        send(r_word(FN_XOR, 10, 5, 6));
        send(r_word(FN_ADD, 11, 8, 9));

        // Dependent multiplies drain the credits
        send(i_word(12, 0, 16'd3));
        send(i_word(13, 0, 16'd5));
        for (int n = 0; n < ROB_DEPTH + 4; n++) begin
            send(mul_word(12, 12, 13));
        end

        // Register 0 and no-ops
        send(r_word(FN_ADD, 0, 1, 2));
        send(i_word(0, 0, 16'd100));
        send(r_word(FN_ADD, 7, 0, 0));
        send({6'h3f, 26'h155_aaaa});   // Unknown opcode
        send(r_word(4'hf, 14, 1, 2));  // Unknown function

        // Random mix over a few registers, dependencies likely
        for (int n = 0; n < NUM_RANDOM; n++) begin
            kind = $urandom_range(0, 7);
            rd   = $urandom_range(0, 7);
            rs1  = $urandom_range(0, 7);
            rs2  = $urandom_range(0, 7);
            case (kind)
                0, 1, 2, 3: send(r_word(4'(kind), rd, rs1, rs2));
                4:          send(i_word(rd, rs1, 16'($urandom)));
                5:          send(mul_word(rd, rs1, rs2));
                6:          send({6'h3f, 26'($urandom)});
                default:    send(r_word(4'h9, rd, rs1, rs2));
            endcase
        end

        while (returned != sent) begin
            @(negedge clock);
        end
        repeat (5) @(negedge clock);

        a_queue_empty: assert (exp_dest_q.size() == 0) else begin
            errors++;
            $display("expected retirements are left over at the end of the run");
        end
        a_credits_back: assert (credits == ROB_DEPTH) else begin
            errors++;
            $display("credit counter ends at %0d", credits);
        end
        a_burst_full: assert (credits_ran_out) else begin
            errors++;
            $display("the burst never used up all credits");
        end

        print_counts();
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Limit grows with the number of words sent
    initial begin : watchdog
        while (cycles <= 40 * sent + 200) begin
            @(posedge clock);
            cycles++;
        end
        $display("run timed out after %0d cycles, %0d of %0d retired", cycles, returned, sent);
        print_counts();
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/ooo_core.sv */
// Top of the out-of-order core slice
// Upstream sends words under credit flow control, one credit back per retirement
`timescale 1ns/1ps
`default_nettype none

module ooo_core import isa_pkg::*, core_pkg::*; #(
    parameter  int ROB_DEPTH = 8,    // Power of two
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        instr_valid,
    input  wire logic [31:0] instr,
    output logic             credit_return,
    output logic             retire_valid,
    output reg_idx_t         retire_dest,
    output data_t            retire_value
);

    ////////////////////////////////////////////////////////////
    // Interconnect
    logic             dec_valid, dec_use_imm;
    op_e              dec_op;
    reg_idx_t         dec_dest, dec_src_a, dec_src_b;
    data_t            dec_imm;
    logic             src_a_pending, src_b_pending;
    logic [TAG_W-1:0] src_a_tag, src_b_tag, alloc_tag;
    data_t            src_a_value, src_b_value;
    logic             alu_ok, mul_ok, issue_valid;
    op_e              issue_op;
    logic [TAG_W-1:0] issue_tag, cdb_tag, retire_tag;
    data_t            issue_a, issue_b, cdb_value;
    logic             cdb_valid;

    assign credit_return = retire_valid;   // One credit per retired instruction

    instr_decode i_instr_decode (
        .clock, .reset, .instr_valid, .instr,
        .dec_valid, .dec_op, .dec_dest, .dec_src_a, .dec_src_b, .dec_imm, .dec_use_imm
    );

    rename_map #(.ROB_DEPTH(ROB_DEPTH)) i_rename_map (
        .clock, .reset, .dec_valid, .dec_dest, .dec_src_a, .dec_src_b, .alloc_tag,
        .retire_valid, .retire_tag, .retire_dest, .retire_value,
        .src_a_pending, .src_a_tag, .src_a_value,
        .src_b_pending, .src_b_tag, .src_b_value
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) i_rob (
        .clock, .reset, .dec_valid, .dec_op, .dec_dest, .dec_use_imm, .dec_imm,
        .src_a_pending, .src_a_tag, .src_a_value,
        .src_b_pending, .src_b_tag, .src_b_value,
        .alloc_tag, .alu_ok, .mul_ok,
        .issue_valid, .issue_op, .issue_tag, .issue_a, .issue_b,
        .cdb_valid, .cdb_tag, .cdb_value,
        .retire_valid, .retire_tag, .retire_dest, .retire_value
    );

    exec_unit #(.ROB_DEPTH(ROB_DEPTH)) i_exec_unit (
        .clock, .reset, .issue_valid, .issue_op, .issue_tag, .issue_a, .issue_b,
        .alu_ok, .mul_ok, .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

`default_nettype wire

/* source/exec_unit.sv */
// Execution units sharing one result bus
// Single-cycle ALU and a three-deep multiply pipeline, kept apart on the bus by alu_ok
`timescale 1ns/1ps
`default_nettype none

module exec_unit import isa_pkg::*, core_pkg::*; #(
    parameter  int ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             issue_valid,
    input  wire op_e              issue_op,
    input  wire logic [TAG_W-1:0] issue_tag,
    input  wire data_t            issue_a,
    input  wire data_t            issue_b,
    output logic                  alu_ok,
    output logic                  mul_ok,
    output logic                  cdb_valid,
    output logic [TAG_W-1:0]      cdb_tag,
    output data_t                 cdb_value
);

    logic             alu_v;
    logic [TAG_W-1:0] alu_tag;
    data_t            alu_res;
    logic [2:0]       mul_v;             // One bit per multiply stage
    logic [TAG_W-1:0] mul_tag [3];
    data_t            mul_a, mul_b;      // Stage one operands
    data_t            mul_p2, mul_p3;    // Product, then output stage

    assign alu_ok = !mul_v[1];   // Stage two reaches the bus next edge
    assign mul_ok = 1'b1;        // Fully pipelined

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_v <= 1'b0;
            mul_v <= '0;
        end else begin
            alu_v <= issue_valid && issue_op != OP_MUL;
            mul_v <= {mul_v[1:0], issue_valid && issue_op == OP_MUL};
        end
    end

    always_ff @(posedge clock) begin
        alu_tag <= issue_tag;
        case (issue_op)
            OP_ADD:  alu_res <= issue_a + issue_b;
            OP_SUB:  alu_res <= issue_a - issue_b;
            OP_AND:  alu_res <= issue_a & issue_b;
            OP_XOR:  alu_res <= issue_a ^ issue_b;
            default: alu_res <= '0;
        endcase
        mul_tag[0] <= issue_tag;
        mul_a      <= issue_a;
        mul_b      <= issue_b;
        mul_tag[1] <= mul_tag[0];
        mul_p2     <= mul_a * mul_b;     // Low word only
        mul_tag[2] <= mul_tag[1];
        mul_p3     <= mul_p2;
    end

    // Shared result bus
    assign cdb_valid = alu_v || mul_v[2];
    assign cdb_tag   = mul_v[2] ? mul_tag[2] : alu_tag;
    assign cdb_value = mul_v[2] ? mul_p3 : alu_res;

    a_bus_collision: assert property (@(posedge clock) disable iff (reset)
        !(alu_v && mul_v[2]))
        else $error("ALU and multiplier finish in the same cycle");

endmodule

`default_nettype wire

/* source/rob.sv */
// Reorder buffer that also acts as the issue window
// Allocates in order, wakes operands from the result bus, issues oldest ready, retires in order
`timescale 1ns/1ps
`default_nettype none

module rob import isa_pkg::*, core_pkg::*; #(
    parameter  int ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             dec_valid,
    input  wire op_e              dec_op,
    input  wire reg_idx_t         dec_dest,
    input  wire logic             dec_use_imm,
    input  wire data_t            dec_imm,
    input  wire logic             src_a_pending,
    input  wire logic [TAG_W-1:0] src_a_tag,
    input  wire data_t            src_a_value,
    input  wire logic             src_b_pending,
    input  wire logic [TAG_W-1:0] src_b_tag,
    input  wire data_t            src_b_value,
    output logic [TAG_W-1:0]      alloc_tag,
    input  wire logic             alu_ok,
    input  wire logic             mul_ok,
    output logic                  issue_valid,
    output op_e                   issue_op,
    output logic [TAG_W-1:0]      issue_tag,
    output data_t                 issue_a,
    output data_t                 issue_b,
    input  wire logic             cdb_valid,
    input  wire logic [TAG_W-1:0] cdb_tag,
    input  wire data_t            cdb_value,
    output logic                  retire_valid,
    output logic [TAG_W-1:0]      retire_tag,
    output reg_idx_t              retire_dest,
    output data_t                 retire_value
);

    ////////////////////////////////////////////////////////////
    // Entry storage
    logic [ROB_DEPTH-1:0] valid, issued, complete;   // Control flags
    logic [ROB_DEPTH-1:0] a_rdy, b_rdy;
    logic [ROB_DEPTH-1:0] can_issue;
    op_e              op      [ROB_DEPTH];
    reg_idx_t         dest    [ROB_DEPTH];
    data_t            a_val   [ROB_DEPTH];
    data_t            b_val   [ROB_DEPTH];
    logic [TAG_W-1:0] a_tag   [ROB_DEPTH];
    logic [TAG_W-1:0] b_tag   [ROB_DEPTH];
    data_t            result  [ROB_DEPTH];

    logic [TAG_W-1:0] head, tail;
    logic [TAG_W:0]   count;
    logic             full;
    logic [DATA_W:0]  res_a, res_b;   // {ready, value} at allocation

    // Ready bit and value for a source entering the buffer
    function automatic logic [DATA_W:0] resolve(input logic pend,
                                                input logic [TAG_W-1:0] tag,
                                                input data_t val);
        if (!pend) return {1'b1, val};
        if (cdb_valid && cdb_tag == tag) return {1'b1, cdb_value};  // Bypass
        if (complete[tag]) return {1'b1, result[tag]};
        return {1'b0, val};                                          // Wait on tag
    endfunction

    assign alloc_tag = tail;
    assign full      = (count == (TAG_W+1)'(ROB_DEPTH));

    // Follows the bus and entry state as well as the lookup
    always_comb begin
        res_a = resolve(src_a_pending, src_a_tag, src_a_value);
        res_b = dec_use_imm ? {1'b1, dec_imm}
                            : resolve(src_b_pending, src_b_tag, src_b_value);
    end

    ////////////////////////////////////////////////////////////
    // Issue select, oldest ready from head
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            can_issue[i] = valid[i] && !issued[i] && a_rdy[i] && b_rdy[i]
                           && ((op[i] == OP_MUL) ? mul_ok : alu_ok);
        end
    end

    always_comb begin : pick_oldest
        logic [TAG_W-1:0] idx;
        issue_valid = 1'b0;
        issue_tag   = head;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            idx = head + TAG_W'(i);
            if (!issue_valid && can_issue[idx]) begin
                issue_valid = 1'b1;
                issue_tag   = idx;
            end
        end
    end

    assign issue_op = op[issue_tag];
    assign issue_a  = a_val[issue_tag];
    assign issue_b  = b_val[issue_tag];

    // Head retires once complete
    assign retire_valid = valid[head] && complete[head];
    assign retire_tag   = head;
    assign retire_dest  = dest[head];
    assign retire_value = result[head];

    ////////////////////////////////////////////////////////////
    // Pointers and flags
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            valid    <= '0;
            issued   <= '0;
            complete <= '0;
        end else begin
            if (issue_valid) issued[issue_tag] <= 1'b1;
            if (cdb_valid) complete[cdb_tag] <= 1'b1;
            if (retire_valid) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            if (dec_valid) begin
                valid[tail]    <= 1'b1;
                issued[tail]   <= (dec_op == OP_NOP);  // NOP never goes to a unit
                complete[tail] <= (dec_op == OP_NOP);
                tail           <= tail + 1'b1;
            end
            count <= count + (TAG_W+1)'(dec_valid) - (TAG_W+1)'(retire_valid);
        end
    end

    ////////////////////////////////////////////////////////////
    // Operands, wakeup and results
    always_ff @(posedge clock) begin
        if (cdb_valid) result[cdb_tag] <= cdb_value;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (cdb_valid && !a_rdy[i] && a_tag[i] == cdb_tag) begin
                a_val[i] <= cdb_value;
                a_rdy[i] <= 1'b1;
            end
            if (cdb_valid && !b_rdy[i] && b_tag[i] == cdb_tag) begin
                b_val[i] <= cdb_value;
                b_rdy[i] <= 1'b1;
            end
        end
        if (dec_valid) begin
            op[tail]     <= dec_op;
            dest[tail]   <= dec_dest;
            result[tail] <= '0;              // NOP retires zero
            {a_rdy[tail], a_val[tail]} <= res_a;
            {b_rdy[tail], b_val[tail]} <= res_b;
            a_tag[tail]  <= src_a_tag;
            b_tag[tail]  <= src_b_tag;
        end
    end

    a_no_alloc_full: assert property (@(posedge clock) disable iff (reset)
        dec_valid |-> !full)
        else $error("allocation into a full reorder buffer");

    a_cdb_target: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> valid[cdb_tag] && !complete[cdb_tag])
        else $error("result bus targets an empty or complete entry");

endmodule

`default_nettype wire

/* source/rename_map.sv */
// Architectural register file plus the register to producer-tag map
// Sources are looked up in the allocation cycle, retirement writes values back
`timescale 1ns/1ps
`default_nettype none

module rename_map import core_pkg::*; #(
    parameter  int ROB_DEPTH = 8,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             dec_valid,
    input  wire reg_idx_t         dec_dest,
    input  wire reg_idx_t         dec_src_a,
    input  wire reg_idx_t         dec_src_b,
    input  wire logic [TAG_W-1:0] alloc_tag,
    input  wire logic             retire_valid,
    input  wire logic [TAG_W-1:0] retire_tag,
    input  wire reg_idx_t         retire_dest,
    input  wire data_t            retire_value,
    output logic                  src_a_pending,
    output logic [TAG_W-1:0]      src_a_tag,
    output data_t                 src_a_value,
    output logic                  src_b_pending,
    output logic [TAG_W-1:0]      src_b_tag,
    output data_t                 src_b_value
);

    data_t             regs [NUM_REGS];
    logic [NUM_REGS-1:0] pending;     // Waiting on an in-flight producer
    logic [TAG_W-1:0]  map_tag [NUM_REGS];

    // Lookup, register 0 never pending and always zero
    assign src_a_pending = pending[dec_src_a];
    assign src_a_tag     = map_tag[dec_src_a];
    assign src_a_value   = (dec_src_a == '0) ? '0 : regs[dec_src_a];
    assign src_b_pending = pending[dec_src_b];
    assign src_b_tag     = map_tag[dec_src_b];
    assign src_b_value   = (dec_src_b == '0) ? '0 : regs[dec_src_b];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (retire_valid && retire_dest != '0) begin
                regs[retire_dest] <= retire_value;  // In-order architectural write
            end
            // Only the youngest producer may clear the mapping
            if (retire_valid && pending[retire_dest] && map_tag[retire_dest] == retire_tag) begin
                pending[retire_dest] <= 1'b0;
            end
            if (dec_valid && dec_dest != '0) begin
                pending[dec_dest] <= 1'b1;     // Wins over a same-cycle clear
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dec_valid && dec_dest != '0) begin
            map_tag[dec_dest] <= alloc_tag;
        end
    end

    // Youngest producer of a real register keeps it pending until it retires
    a_retire_pending: assert property (@(posedge clock) disable iff (reset)
        retire_valid && retire_dest != '0 && map_tag[retire_dest] == retire_tag
        |-> pending[retire_dest])
        else $error("retiring producer named by the map is not pending");

endmodule

`default_nettype wire

/* source/instr_decode.sv */
// Decode stage of the core slice
// Splits each accepted word into op, registers and immediate, one register stage deep
`timescale 1ns/1ps
`default_nettype none

module instr_decode import isa_pkg::*, core_pkg::*; (
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire logic     instr_valid,
    input  wire instr_u   instr,
    output logic          dec_valid,
    output op_e           dec_op,
    output reg_idx_t      dec_dest,
    output reg_idx_t      dec_src_a,
    output reg_idx_t      dec_src_b,
    output data_t         dec_imm,
    output logic          dec_use_imm
);

    op_e      op_d;
    reg_idx_t dest_d;
    logic     use_imm_d;

    always_comb begin
        op_d      = OP_NOP;
        dest_d    = '0;                 // No destination unless decoded
        use_imm_d = 1'b0;
        case (instr.r.opcode)
            OPC_ALU: begin
                dest_d = instr.r.rd;
                case (instr.r.funct)
                    FN_ADD:  op_d = OP_ADD;
                    FN_SUB:  op_d = OP_SUB;
                    FN_AND:  op_d = OP_AND;
                    FN_XOR:  op_d = OP_XOR;
                    default: dest_d = '0;  // Unknown function, no-op
                endcase
            end
            OPC_ADDI: begin
                op_d      = OP_ADD;
                dest_d    = instr.i.rd;
                use_imm_d = 1'b1;
            end
            OPC_MUL: begin
                op_d   = OP_MUL;
                dest_d = instr.r.rd;
            end
            default: ;                   // Unknown opcode passes as no-op
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    // Payload, qualified by dec_valid
    always_ff @(posedge clock) begin
        dec_op      <= op_d;
        dec_dest    <= dest_d;
        dec_src_a   <= instr.r.rs1;     // Same field in both forms
        dec_src_b   <= instr.r.rs2;
        dec_imm     <= {{(DATA_W-16){instr.i.imm[15]}}, instr.i.imm};  // Sign extend
        dec_use_imm <= use_imm_d;
    end

endmodule

`default_nettype wire

/* source/core_pkg.sv */
// Datapath sizes shared by every block of the core slice
`default_nettype none

package core_pkg;

    parameter int DATA_W   = 32;
    parameter int NUM_REGS = 32;

    // Architectural register index
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    // One data word
    typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

/* source/isa_pkg.sv */
// Instruction set of the core slice
// Opcode and function encodings, the two views of an instruction word, decoded ops
`default_nettype none

package isa_pkg;

    // Major opcode in bits 31:26
    typedef enum logic [5:0] {
        OPC_ALU  = 6'h00,  // Register form, function picks the op
        OPC_ADDI = 6'h08,
        OPC_MUL  = 6'h1c
    } opcode_e;

    typedef enum logic [3:0] {
        FN_ADD = 4'h0,
        FN_SUB = 4'h1,
        FN_AND = 4'h2,
        FN_XOR = 4'h3
    } funct_e;

    // Register form
    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  pad;     // Reserved, ignored
        funct_e      funct;
    } instr_r_t;

    // Immediate form
    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [15:0] imm;     // Signed
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL
    } op_e;

endpackage

`default_nettype wire
